//--- hdl/nn_dims_pkg.sv
package nn_dims_pkg;

    // ======================================================================
    // network sizes
    // ======================================================================

    // 28x28 input image, flattened row by row
    localparam int N_IN = 784;
    // hidden layer width
    localparam int N_HID = 32;
    // output classes
    localparam int N_OUT = 10;
    // hidden activations are scaled down by this before layer 2
    localparam int HID_SHIFT = 8;

    // ======================================================================
    // data types
    // ======================================================================

    // raw pixel, unsigned
    typedef logic [7:0] pixel_t;
    // weights of both layers
    typedef logic signed [7:0] weight_t;
    // biases of both layers
    typedef logic signed [31:0] bias_t;
    // stored hidden value, also the shifted value fed to layer 2
    typedef logic signed [31:0] hidden_t;
    // dot product accumulator, wide enough that no sum can wrap
    typedef logic signed [63:0] acc_t;

    // ======================================================================
    // index and address types
    // ======================================================================

    // 0 .. N_IN-1
    typedef logic [9:0] pix_addr_t;
    // 0 .. N_HID-1
    typedef logic [4:0] hid_idx_t;
    // 0 .. N_OUT-1
    typedef logic [3:0] class_t;
    // row-major, neuron * N_IN + pixel
    typedef logic [14:0] w1_addr_t;
    // row-major, class * N_HID + hidden index
    typedef logic [8:0] w2_addr_t;

endpackage

//--- hdl/nn_ctrl_pkg.sv
package nn_ctrl_pkg;

    // ======================================================================
    // memory read requests
    // ======================================================================

    // layer 1 weight memory
    typedef struct packed {
        logic                 en;
        nn_dims_pkg::w1_addr_t addr;
    } w1_req_t;

    // layer 2 weight memory
    typedef struct packed {
        logic                 en;
        nn_dims_pkg::w2_addr_t addr;
    } w2_req_t;

    // layer 1 bias memory, one word per hidden neuron
    typedef struct packed {
        logic                 en;
        nn_dims_pkg::hid_idx_t addr;
    } b1_req_t;

    // layer 2 bias memory, one word per class
    typedef struct packed {
        logic                en;
        nn_dims_pkg::class_t addr;
    } b2_req_t;

    // ======================================================================
    // datapath control
    // ======================================================================

    // host pixel write
    typedef struct packed {
        logic                  we;
        nn_dims_pkg::pix_addr_t addr;
        nn_dims_pkg::pixel_t    data;
    } pix_wr_t;

    // one term of a dot product, aligned with the returning data
    // idx is the hidden neuron in layer 1 and the class in layer 2
    typedef struct packed {
        logic                  valid;
        logic                  first;
        logic                  last;
        nn_dims_pkg::hid_idx_t idx;
    } mac_ctl_t;

    // hidden activation write-back
    typedef struct packed {
        logic                  we;
        nn_dims_pkg::hid_idx_t idx;
        nn_dims_pkg::hidden_t  data;
    } hid_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        L1_RUN,
        L1_DRAIN,
        L2_RUN,
        L2_DRAIN,
        DONE
    } seq_state_t;

endpackage

//--- hdl/nn_sequencer.sv
`timescale 1ns/1ps

module nn_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    output logic                   done,
    output nn_ctrl_pkg::w1_req_t   w1_req,
    output nn_ctrl_pkg::b1_req_t   b1_req,
    output nn_ctrl_pkg::w2_req_t   w2_req,
    output nn_ctrl_pkg::b2_req_t   b2_req,
    output nn_dims_pkg::pix_addr_t pix_rd_addr,
    output nn_dims_pkg::hid_idx_t  hid_rd_addr,
    output nn_ctrl_pkg::mac_ctl_t  l1_ctl,
    output nn_ctrl_pkg::mac_ctl_t  l2_ctl,
    output logic                   last_class
);
    import nn_dims_pkg::*;
    import nn_ctrl_pkg::*;

    seq_state_t state;
    logic       start_d;
    logic       start_rise;
    pix_addr_t  pix_cnt;
    hid_idx_t   hid_cnt;
    class_t     cls_cnt;
    // two-cycle drain timer
    logic       drain_cnt;

    // flags for the term issued this cycle
    mac_ctl_t   l1_issue;
    mac_ctl_t   l2_issue;
    logic       last_class_issue;

    // a run only begins on a new rising edge
    assign start_rise = start & ~start_d;
    assign done = (state == DONE);

    // ======================================================================
    // address issue
    // ======================================================================

    // layer 1 weight address, neuron-major
    assign w1_req.en   = (state == L1_RUN);
    assign w1_req.addr = w1_addr_t'(hid_cnt) * w1_addr_t'(N_IN) + w1_addr_t'(pix_cnt);
    // bias fetched alongside the first weight of each neuron
    assign b1_req.en   = (state == L1_RUN) && (pix_cnt == '0);
    assign b1_req.addr = hid_cnt;

    // layer 2 weight address, class-major
    assign w2_req.en   = (state == L2_RUN);
    assign w2_req.addr = w2_addr_t'(cls_cnt) * w2_addr_t'(N_HID) + w2_addr_t'(hid_cnt);
    assign b2_req.en   = (state == L2_RUN) && (hid_cnt == '0);
    assign b2_req.addr = cls_cnt;

    // buffers read in the same cycle as the weight memories
    assign pix_rd_addr = pix_cnt;
    assign hid_rd_addr = hid_cnt;

    always_comb begin
        l1_issue.valid   = (state == L1_RUN);
        l1_issue.first   = (pix_cnt == '0);
        l1_issue.last    = (pix_cnt == pix_addr_t'(N_IN - 1));
        l1_issue.idx     = hid_cnt;
        l2_issue.valid   = (state == L2_RUN);
        l2_issue.first   = (hid_cnt == '0);
        l2_issue.last    = (hid_cnt == hid_idx_t'(N_HID - 1));
        l2_issue.idx     = hid_idx_t'(cls_cnt);
        last_class_issue = (cls_cnt == class_t'(N_OUT - 1));
    end

    // delay by one so the flags line up with memory data
    always_ff @(posedge clk) begin
        if (rst) begin
            l1_ctl     <= '0;
            l2_ctl     <= '0;
            last_class <= 1'b0;
        end else begin
            l1_ctl     <= l1_issue;
            l2_ctl     <= l2_issue;
            last_class <= last_class_issue;
        end
    end

    // ======================================================================
    // FSM and loop counters
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            start_d   <= 1'b0;
            pix_cnt   <= '0;
            hid_cnt   <= '0;
            cls_cnt   <= '0;
            drain_cnt <= 1'b0;
        end else begin
            start_d <= start;
            case (state)
                IDLE: begin
                    if (start_rise) begin
                        pix_cnt <= '0;
                        hid_cnt <= '0;
                        cls_cnt <= '0;
                        state   <= L1_RUN;
                    end
                end
                L1_RUN: begin
                    // one term per cycle, no gap between neurons
                    if (pix_cnt == pix_addr_t'(N_IN - 1)) begin
                        pix_cnt <= '0;
                        hid_cnt <= hid_cnt + 1'b1;
                        if (hid_cnt == hid_idx_t'(N_HID - 1)) begin
                            state <= L1_DRAIN;
                        end
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
                L1_DRAIN: begin
                    // let the last hidden write land
                    drain_cnt <= ~drain_cnt;
                    if (drain_cnt) begin
                        state <= L2_RUN;
                    end
                end
                L2_RUN: begin
                    if (hid_cnt == hid_idx_t'(N_HID - 1)) begin
                        hid_cnt <= '0;
                        if (cls_cnt == class_t'(N_OUT - 1)) begin
                            cls_cnt <= '0;
                            state   <= L2_DRAIN;
                        end else begin
                            cls_cnt <= cls_cnt + 1'b1;
                        end
                    end else begin
                        hid_cnt <= hid_cnt + 1'b1;
                    end
                end
                L2_DRAIN: begin
                    // predicted commits during this wait
                    drain_cnt <= ~drain_cnt;
                    if (drain_cnt) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // hold until the host drops start
                    if (!start) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/pixel_buffer.sv
`timescale 1ns/1ps

module pixel_buffer (
    input  logic                   clk,
    input  nn_ctrl_pkg::pix_wr_t   pix_wr,
    input  nn_dims_pkg::pix_addr_t rd_addr,
    output nn_dims_pkg::pixel_t    rd_data
);
    import nn_dims_pkg::*;

    // one byte per pixel, row-major image
    pixel_t mem [N_IN];

    // host write port
    always_ff @(posedge clk) begin
        // addresses past the image are dropped
        if (pix_wr.we && (pix_wr.addr < pix_addr_t'(N_IN))) begin
            mem[pix_wr.addr] <= pix_wr.data;
        end
    end

    // registered read, lands with the w1 memory data
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/hidden_buffer.sv
`timescale 1ns/1ps

module hidden_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  nn_ctrl_pkg::hid_wr_t  hid_wr,
    input  nn_dims_pkg::hid_idx_t rd_addr,
    output nn_dims_pkg::hidden_t  rd_scaled
);
    import nn_dims_pkg::*;

    // ======================================================================
    // storage
    // ======================================================================

    // one activation per hidden neuron, written by layer 1
    hidden_t mem [N_HID];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_HID; i++) begin
                mem[i] <= '0;
            end
        end else if (hid_wr.we) begin
            mem[hid_wr.idx] <= hid_wr.data;
        end
    end

    // ======================================================================
    // read port
    // ======================================================================

    // arithmetic shift keeps the sign, so this is floor division by 2^HID_SHIFT
    always_ff @(posedge clk) begin
        rd_scaled <= mem[rd_addr] >>> HID_SHIFT;
    end

endmodule

//--- hdl/layer1_neuron.sv
`timescale 1ns/1ps

module layer1_neuron (
    input  logic                  clk,
    input  logic                  rst,
    input  nn_ctrl_pkg::mac_ctl_t ctl,
    input  nn_dims_pkg::pixel_t   pixel,
    input  nn_dims_pkg::weight_t  weight,
    input  nn_dims_pkg::bias_t    bias,
    output nn_ctrl_pkg::hid_wr_t  hid_wr
);
    import nn_dims_pkg::*;

    // signed weight times zero-extended pixel
    logic signed [16:0] prod;
    acc_t  acc_q;
    acc_t  acc_next;
    acc_t  sum;
    bias_t bias_q;
    bias_t bias_use;

    assign prod = weight * $signed({1'b0, pixel});

    // restart on the first term of each neuron
    assign acc_next = (ctl.first ? acc_t'(0) : acc_q) + acc_t'(prod);
    // bias memory answers only in the first cycle
    assign bias_use = ctl.first ? bias : bias_q;
    assign sum      = acc_next + acc_t'(bias_use);

    // running sum and held bias
    always_ff @(posedge clk) begin
        if (ctl.valid) begin
            acc_q <= acc_next;
            if (ctl.first) begin
                bias_q <= bias;
            end
        end
    end

    // write-back, one cycle after the last term
    always_ff @(posedge clk) begin
        if (rst) begin
            hid_wr <= '0;
        end else begin
            hid_wr.we  <= ctl.valid && ctl.last;
            hid_wr.idx <= ctl.idx;
            // relu, then low 32 bits
            if (sum > 0) begin
                hid_wr.data <= hidden_t'(sum[31:0]);
            end else begin
                hid_wr.data <= '0;
            end
        end
    end

endmodule

//--- hdl/layer2_scorer.sv
`timescale 1ns/1ps

module layer2_scorer (
    input  logic                  clk,
    input  logic                  rst,
    input  nn_ctrl_pkg::mac_ctl_t ctl,
    input  logic                  last_class,
    input  nn_dims_pkg::weight_t  weight,
    input  nn_dims_pkg::hidden_t  hscaled,
    input  nn_dims_pkg::bias_t    bias,
    output nn_dims_pkg::class_t   predicted
);
    import nn_dims_pkg::*;

    // ======================================================================
    // dot product
    // ======================================================================

    // int8 times int32
    logic signed [39:0] prod;
    acc_t   acc_q;
    acc_t   acc_next;
    acc_t   score;
    bias_t  bias_q;
    bias_t  bias_use;
    class_t cls;

    assign prod     = weight * hscaled;
    assign acc_next = (ctl.first ? acc_t'(0) : acc_q) + acc_t'(prod);
    assign bias_use = ctl.first ? bias : bias_q;
    // only meaningful on the last term of a class
    assign score    = acc_next + acc_t'(bias_use);
    assign cls      = ctl.idx[3:0];

    always_ff @(posedge clk) begin
        if (ctl.valid) begin
            acc_q <= acc_next;
            if (ctl.first) begin
                bias_q <= bias;
            end
        end
    end

    // ======================================================================
    // argmax
    // ======================================================================

    acc_t   best_val;
    class_t best_idx;
    logic   take;

    // class 0 seeds the search, later ones must be strictly greater
    // so ties keep the lower index
    assign take = (cls == '0) || (score > best_val);

    always_ff @(posedge clk) begin
        if (ctl.valid && ctl.last && take) begin
            best_val <= score;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            best_idx  <= '0;
            predicted <= '0;
        end else if (ctl.valid && ctl.last) begin
            if (take) begin
                best_idx <= cls;
            end
            // final class commits the winner
            if (last_class) begin
                predicted <= take ? cls : best_idx;
            end
        end
    end

endmodule

//--- hdl/nn_core.sv
`timescale 1ns/1ps

module nn_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 done,
    input  nn_ctrl_pkg::pix_wr_t pix_wr,
    output nn_ctrl_pkg::w1_req_t w1_req,
    output nn_ctrl_pkg::b1_req_t b1_req,
    output nn_ctrl_pkg::w2_req_t w2_req,
    output nn_ctrl_pkg::b2_req_t b2_req,
    input  nn_dims_pkg::weight_t w1_dout,
    input  nn_dims_pkg::bias_t   b1_dout,
    input  nn_dims_pkg::weight_t w2_dout,
    input  nn_dims_pkg::bias_t   b2_dout,
    output nn_dims_pkg::class_t  predicted
);
    import nn_dims_pkg::*;
    import nn_ctrl_pkg::*;

    // ======================================================================
    // internal nets
    // ======================================================================

    pix_addr_t pix_rd_addr;
    hid_idx_t  hid_rd_addr;
    mac_ctl_t  l1_ctl;
    mac_ctl_t  l2_ctl;
    logic      last_class;
    pixel_t    pixel;
    hidden_t   hscaled;
    hid_wr_t   hid_wr;

    // control and memory addressing
    nn_sequencer u_seq (
        .clk, .rst, .start, .done,
        .w1_req, .b1_req, .w2_req, .b2_req,
        .pix_rd_addr, .hid_rd_addr,
        .l1_ctl, .l2_ctl, .last_class
    );

    // input image
    pixel_buffer u_pix (
        .clk, .pix_wr, .rd_addr(pix_rd_addr), .rd_data(pixel)
    );

    // hidden layer
    layer1_neuron u_l1 (
        .clk, .rst, .ctl(l1_ctl), .pixel, .weight(w1_dout),
        .bias(b1_dout), .hid_wr
    );

    hidden_buffer u_hid (
        .clk, .rst, .hid_wr, .rd_addr(hid_rd_addr), .rd_scaled(hscaled)
    );

    // output layer and argmax
    layer2_scorer u_l2 (
        .clk, .rst, .ctl(l2_ctl), .last_class, .weight(w2_dout),
        .hscaled, .bias(b2_dout), .predicted
    );

endmodule

//--- tests/weight_roms.sv
`timescale 1ns/1ps

module weight_roms (
    input  logic                 clk,
    input  nn_ctrl_pkg::w1_req_t w1_req,
    input  nn_ctrl_pkg::b1_req_t b1_req,
    input  nn_ctrl_pkg::w2_req_t w2_req,
    input  nn_ctrl_pkg::b2_req_t b2_req,
    output nn_dims_pkg::weight_t w1_dout,
    output nn_dims_pkg::bias_t   b1_dout,
    output nn_dims_pkg::weight_t w2_dout,
    output nn_dims_pkg::bias_t   b2_dout
);
    import nn_dims_pkg::*;

    // contents are written by the testbench through hierarchical references
    weight_t w1 [N_IN * N_HID];
    bias_t   b1 [N_HID];
    weight_t w2 [N_HID * N_OUT];
    bias_t   b2 [N_OUT];

    // outputs start out defined so the DUT never sees X on its inputs
    initial begin
        w1_dout = '0;
        b1_dout = '0;
        w2_dout = '0;
        b2_dout = '0;
    end

    // one-cycle read latency, output holds while en is low
    always @(posedge clk) begin
        if (w1_req.en) w1_dout <= w1[w1_req.addr];
        if (b1_req.en) b1_dout <= b1[b1_req.addr];
        if (w2_req.en) w2_dout <= w2[w2_req.addr];
        if (b2_req.en) b2_dout <= b2[b2_req.addr];
    end

endmodule

//--- tests/nn_core_tb.sv
`timescale 1ns/1ps

module nn_core_tb;
    import nn_dims_pkg::*;
    import nn_ctrl_pkg::*;

    localparam int     N_RUNS      = 9;
    localparam longint RUN_CYCLES  = N_IN * N_HID + N_HID * N_OUT + 50;
    // whole test budget in ns at twice the nominal length
    localparam longint WATCHDOG_NS = 2 * N_RUNS * RUN_CYCLES * 4;

    logic    clk;
    logic    rst;
    logic    start;
    logic    done;
    pix_wr_t pix_wr;
    w1_req_t w1_req;
    b1_req_t b1_req;
    w2_req_t w2_req;
    b2_req_t b2_req;
    weight_t w1_dout;
    bias_t   b1_dout;
    weight_t w2_dout;
    bias_t   b2_dout;
    class_t  predicted;

    // testbench copy of the image that the reference model reads
    pixel_t  pix [N_IN];
    class_t  exp_class;
    // high while the core should sit idle between runs
    logic    quiet;
    logic    any_en;
    int      errors;

    assign any_en = w1_req.en | b1_req.en | w2_req.en | b2_req.en;

    nn_core DUT (
        .clk, .rst, .start, .done, .pix_wr,
        .w1_req, .b1_req, .w2_req, .b2_req,
        .w1_dout, .b1_dout, .w2_dout, .b2_dout,
        .predicted
    );

    weight_roms ROM (
        .clk, .w1_req, .b1_req, .w2_req, .b2_req,
        .w1_dout, .b1_dout, .w2_dout, .b2_dout
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // checks
    // ======================================================================

    // state right after reset
    a_reset_done: assert property (@(posedge clk) $fell(rst) |-> !done)
        else begin
            errors++;
            $display("** Error at time %0t: done expected 0 actual %0b",
                     $time, $sampled(done));
        end
    a_reset_pred: assert property (@(posedge clk) $fell(rst) |-> predicted == '0)
        else begin
            errors++;
            $display("** Error at time %0t: predicted expected 0 actual %0d",
                     $time, $sampled(predicted));
        end
    a_reset_hid: assert property (@(posedge clk) $fell(rst) |-> !DUT.hid_wr.we)
        else begin
            errors++;
            $display("** Error at time %0t: hid_wr.we expected 0 actual %0b",
                     $time, $sampled(DUT.hid_wr.we));
        end

    // no memory traffic once done or while idle
    a_quiet: assert property (@(posedge clk) disable iff (rst) (done || quiet) |-> !any_en)
        else begin
            errors++;
            $display("** Error at time %0t: any_en expected 0 actual %0b",
                     $time, $sampled(any_en));
        end

    // level handshake
    a_hold: assert property (@(posedge clk) disable iff (rst) done && start |=> done)
        else begin
            errors++;
            $display("** Error at time %0t: done expected 1 actual %0b",
                     $time, $sampled(done));
        end
    a_fall: assert property (@(posedge clk) disable iff (rst) done && !start |=> !done)
        else begin
            errors++;
            $display("** Error at time %0t: done expected 0 actual %0b",
                     $time, $sampled(done));
        end

    // class is already committed when done rises
    a_result: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> predicted == exp_class)
        else begin
            errors++;
            $display("** Error at time %0t: predicted expected %0d actual %0d",
                     $time, exp_class, $sampled(predicted));
        end

    // ======================================================================
    // reference model and stimulus
    // ======================================================================

    // integer network with relu, low 32 bits, shift by 8 and lowest index on ties
    function automatic class_t model_class();
        longint acc;
        longint best;
        int     hid [N_HID];
        class_t best_k;
        best   = 0;
        best_k = '0;
        for (int j = 0; j < N_HID; j++) begin
            acc = longint'(ROM.b1[j]);
            for (int i = 0; i < N_IN; i++) begin
                acc += longint'(ROM.w1[j * N_IN + i]) * longint'(pix[i]);
            end
            hid[j] = (acc > 0) ? int'(acc[31:0]) : 0;
            hid[j] = hid[j] >>> HID_SHIFT;
        end
        for (int k = 0; k < N_OUT; k++) begin
            acc = longint'(ROM.b2[k]);
            for (int j = 0; j < N_HID; j++) begin
                acc += longint'(ROM.w2[k * N_HID + j]) * longint'(hid[j]);
            end
            if (k == 0 || acc > best) begin
                best   = acc;
                best_k = class_t'(k);
            end
        end
        return best_k;
    endfunction

    // one pixel per cycle through the host port
    task automatic write_image();
        for (int i = 0; i < N_IN; i++) begin
            @(negedge clk);
            pix_wr = '{1'b1, pix_addr_t'(i), pix[i]};
        end
        @(negedge clk);
        pix_wr.we = 1'b0;
    endtask

    task automatic write_stray(input int addr, input pixel_t data);
        @(negedge clk);
        pix_wr = '{1'b1, pix_addr_t'(addr), data};
        @(negedge clk);
        pix_wr.we = 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < N_IN; i++) pix[i] = pixel_t'($urandom);
        for (int i = 0; i < N_IN * N_HID; i++) ROM.w1[i] = weight_t'($urandom);
        for (int i = 0; i < N_HID * N_OUT; i++) ROM.w2[i] = weight_t'($urandom);
        for (int j = 0; j < N_HID; j++) ROM.b1[j] = int'($urandom_range(200000)) - 100000;
        for (int k = 0; k < N_OUT; k++) ROM.b2[k] = int'($urandom_range(100000)) - 50000;
        write_image();
    endtask

    // full start/done cycle with start held a while past done
    task automatic run_once(input int hold_cycles);
        @(negedge clk);
        exp_class = model_class();
        quiet     = 1'b0;
        start     = 1'b1;
        while (!done) @(negedge clk);
        repeat (hold_cycles) @(negedge clk);
        start = 1'b0;
        while (done) @(negedge clk);
        quiet = 1'b1;
        repeat (5) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h490a_f390));
        rst       = 1'b1;
        start     = 1'b0;
        pix_wr    = '0;
        quiet     = 1'b0;
        exp_class = '0;
        errors    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        quiet = 1'b1;
        repeat (5) @(negedge clk);

        // random networks
        repeat (4) begin
            fill_random();
            run_once(3);
        end

        // zero weights and two equal b2 maxima at 3 and 7
        fill_random();
        for (int i = 0; i < N_IN * N_HID; i++) ROM.w1[i] = '0;
        for (int i = 0; i < N_HID * N_OUT; i++) ROM.w2[i] = '0;
        for (int k = 0; k < N_OUT; k++) ROM.b2[k] = k - 1000;
        ROM.b2[3] = 5000;
        ROM.b2[7] = 5000;
        run_once(1);

        // b1 far below any reachable dot product so relu zeroes every hidden value
        fill_random();
        for (int j = 0; j < N_HID; j++) ROM.b1[j] = -(1 <<< 30);
        // long hold where no second run may start
        run_once(40);

        // writes past the image must not disturb it
        fill_random();
        run_once(1);
        write_stray(N_IN, 8'hff);
        write_stray(1023, 8'h5a);
        run_once(1);

        // new image on the same network
        for (int i = 0; i < N_IN; i++) pix[i] = pixel_t'($urandom);
        write_image();
        run_once(1);

        $display("all runs finished, %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all runs finished, %0d errors so far", errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- all.f
hdl/nn_dims_pkg.sv
hdl/nn_ctrl_pkg.sv
hdl/nn_sequencer.sv
hdl/pixel_buffer.sv
hdl/hidden_buffer.sv
hdl/layer1_neuron.sv
hdl/layer2_scorer.sv
hdl/nn_core.sv
tests/weight_roms.sv
tests/nn_core_tb.sv
